/* compile.f */
design/clk_div_pkg.sv
design/rate_ctrl.sv
design/lane_mix_pipe.sv
design/clk_div_mixer.sv
verification/clk_div_mixer_sva.sv
verification/clk_div_mixer_tb.sv

/* run.sh */
#!/bin/sh
# Build the mixer testbench with Verilator, run it, and judge the log
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert -f compile.f --top-module clk_div_mixer_tb \
    -o clk_div_mixer_sim > "$LOG" 2>&1 \
    && ./obj_dir/clk_div_mixer_sim >> "$LOG" 2>&1 \
    || echo "Build or simulation exited with an error" >> "$LOG"
if grep -q "Result: FAILED" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
grep -q "Result: PASSED" "$LOG" || { echo "No passing result in $LOG"; exit 1; }
echo "Simulation passed"

/* verification/clk_div_mixer_tb.sv */
// ==============================
// Testbench for the divided-rate byte mixer. Runs a stimulus table against
// a reference model of the counter and the four lane pipelines.
// ==============================

`default_nettype none

module clk_div_mixer_tb;

    import clk_div_pkg::*;

    // ==============================
    // DUT signals and clock
    // ==============================

    logic       gclk;
    logic       rst_n;
    logic       enable;
    lane_en_t   lane_en;
    lane_word_t data_in;
    lane_word_t data_out;

    int unsigned error_count;
    int unsigned cycle_cnt;

    // Period of 100 time units
    always #50 gclk = ~gclk;

    clk_div_mixer clk_div_mixer_i (
        .gclk     (gclk),
        .rst_n    (rst_n),
        .enable   (enable),
        .lane_en  (lane_en),
        .data_in  (data_in),
        .data_out (data_out)
    );

    // ==============================
    // Stimulus table
    // ==============================

    // One row per phase, data_in is the base XOR a fresh random word each cycle
    typedef struct packed {
        logic        en;
        lane_en_t    len;
        lane_word_t  base;
        logic [15:0] cycles;
    } stim_row_t;

    localparam int num_rows = 8;

    // Lane enable bits are div8, div4, div2, main from the left
    // First row ends with the counter off its wrap point, so the hold keeps a nonzero phase
    localparam stim_row_t stim_table [num_rows] = '{
        '{1'b1, 4'b1111, 32'h0000_0000, 16'd43},   // All rates running
        '{1'b0, 4'b1111, 32'h5A5A_5A5A, 16'd12},   // Divided lanes hold
        '{1'b1, 4'b1111, 32'h0000_0000, 16'd16},   // Counter resumes
        '{1'b1, 4'b1011, 32'h0F0F_0F0F, 16'd20},   // div4 frozen
        '{1'b1, 4'b1101, 32'h0000_0000, 16'd20},   // div2 frozen
        '{1'b1, 4'b0111, 32'hFF00_FF00, 16'd24},   // div8 frozen
        '{1'b1, 4'b1110, 32'h0000_0000, 16'd12},   // Main lane frozen
        '{1'b1, 4'b1111, 32'h0000_0000, 16'd200}   // Long random run
    };

    function automatic int unsigned total_stim_cycles();
        int unsigned sum;
        sum = 0;
        for (int r = 0; r < num_rows; r++) begin
            sum += int'(stim_table[r].cycles);
        end
        return sum;
    endfunction

    // ==============================
    // Reference model
    // ==============================

    logic [2:0] m_cnt;
    logic [7:0] m_stage [4][8];

    // Offsets by lane index, main first
    function automatic logic [7:0] lane_offset_of(input int lane);
        case (lane)
            0:       return 8'hAA;
            1:       return 8'h01;
            2:       return 8'h02;
            default: return 8'h04;
        endcase
    endfunction

    function automatic logic [31:0] model_word();
        return {m_stage[3][7], m_stage[2][7], m_stage[1][7], m_stage[0][7]};
    endfunction

    // Steps the model on every rising edge, inputs are stable here
    always @(posedge gclk or negedge rst_n) begin : model_step
        logic [7:0]  old_s [8];
        logic [3:0]  adv_now;
        logic [31:0] din_flat;
        if (!rst_n) begin
            m_cnt = 3'd0;
            for (int l = 0; l < 4; l++) begin
                for (int s = 0; s < 8; s++) begin
                    m_stage[l][s] = 8'h00;
                end
            end
        end else begin
            din_flat = data_in;
            // Rates follow the enabled edge count modulo 2, 4 and 8
            adv_now[0] = lane_en.main;
            adv_now[1] = enable && (m_cnt inside {3'd1, 3'd3, 3'd5, 3'd7}) && lane_en.div2;
            adv_now[2] = enable && (m_cnt inside {3'd3, 3'd7}) && lane_en.div4;
            adv_now[3] = enable && (m_cnt == 3'd7) && lane_en.div8;
            for (int l = 0; l < 4; l++) begin
                if (adv_now[l]) begin
                    for (int s = 0; s < 8; s++) begin
                        old_s[s] = m_stage[l][s];
                    end
                    m_stage[l][0] = din_flat[8*l +: 8];
                    m_stage[l][1] = old_s[0] + lane_offset_of(l);
                    m_stage[l][2] = old_s[1] ^ old_s[0];
                    m_stage[l][3] = old_s[2] & old_s[1];
                    m_stage[l][4] = old_s[3] | old_s[2];
                    m_stage[l][5] = old_s[4] + old_s[3];
                    m_stage[l][6] = old_s[5] - old_s[4];
                    m_stage[l][7] = old_s[6] ^ old_s[5];
                end
            end
            if (enable) begin
                m_cnt = m_cnt + 3'd1;
            end
        end
    end

    // ==============================
    // Check and timeout
    // ==============================

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            error_count++;
            $display("FAIL at %0t: %s, data_out %h expected %h", $time, what, got, expected);
            $display("Result: FAILED");
            $fatal(1, "data_out mismatch");
        end
    endtask

    // Limit is the table length plus a margin for reset
    always @(posedge gclk) begin
        cycle_cnt++;
        if (cycle_cnt > total_stim_cycles() + 50) begin
            $display("Timeout: run went past %0d cycles", total_stim_cycles() + 50);
            $display("Result: FAILED");
            $fatal(1, "run did not finish in time");
        end
    end

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        stim_row_t row;
        gclk        = 1'b0;
        rst_n       = 1'b0;
        // Rate and lane inputs active, reset alone keeps strobes and lanes idle
        enable      = 1'b1;
        lane_en     = '1;
        data_in     = '0;
        error_count = 0;
        cycle_cnt   = 0;
        void'($urandom(32'he1f2));

        // Output stays zero through reset
        repeat (3) begin
            @(negedge gclk);
            check_value(data_out, 32'h0, "during reset");
        end
        rst_n = 1'b1;

        // Drive on the falling edge, compare on the next one
        for (int r = 0; r < num_rows; r++) begin
            row = stim_table[r];
            for (int c = 0; c < int'(row.cycles); c++) begin
                enable  = row.en;
                lane_en = row.len;
                data_in = row.base ^ $urandom();
                @(negedge gclk);
                check_value(data_out, model_word(), $sformatf("row %0d cycle %0d", r, c));
            end
        end

        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/clk_div_mixer_sva.sv */
// ==============================
// Assertions on the rate controller strobes, bound into rate_ctrl
// ==============================

`default_nettype none

module clk_div_mixer_sva (
    input logic                   gclk,
    input logic                   rst_n,
    input logic                   enable,
    input clk_div_pkg::lane_en_t  lane_en,
    input clk_div_pkg::lane_adv_t adv
);

    // Slower ticks are a subset of faster ones, when that lane is on
    a_div8_in_div4 : assert property (@(posedge gclk) disable iff (!rst_n)
        (adv.div8 && lane_en.div4) |-> adv.div4)
        else $error("div8 advance without div4 advance");

    a_div4_in_div2 : assert property (@(posedge gclk) disable iff (!rst_n)
        (adv.div4 && lane_en.div2) |-> adv.div2)
        else $error("div4 advance without div2 advance");

    // Counter is halted, so no divided lane may step
    a_hold_when_off : assert property (@(posedge gclk) disable iff (!rst_n)
        !enable |-> !(adv.div2 || adv.div4 || adv.div8))
        else $error("divided advance while enable is low");

    // Counter sits at 0 in reset, no divided strobe
    a_reset_idle : assert property (@(posedge gclk)
        !rst_n |-> !(adv.div2 || adv.div4 || adv.div8))
        else $error("divided advance during reset");

endmodule

bind rate_ctrl clk_div_mixer_sva clk_div_mixer_sva_i (
    .gclk    (gclk),
    .rst_n   (rst_n),
    .enable  (enable),
    .lane_en (lane_en),
    .adv     (adv)
);

`default_nettype wire

/* design/clk_div_mixer.sv */
// ==============================
// Top level of the divided-rate byte mixer. One rate controller drives
// four lane pipelines, their bytes form the output word.
// ==============================

`default_nettype none

module clk_div_mixer (
    input  logic                    gclk,
    input  logic                    rst_n,
    input  logic                    enable,
    input  clk_div_pkg::lane_en_t   lane_en,
    input  clk_div_pkg::lane_word_t data_in,
    output clk_div_pkg::lane_word_t data_out
);

    import clk_div_pkg::*;

    // ==============================
    // Lane setup
    // ==============================

    // Offsets by lane index, main first
    localparam lane_byte_t lane_off [num_lanes] = '{off_main, off_div2, off_div4, off_div8};

    // Strobes from the controller
    lane_adv_t adv;

    // Flat views, bit 0 and byte 0 belong to the main lane
    logic [num_lanes-1:0]        adv_bits;
    logic [num_lanes*lane_w-1:0] din_bits;
    logic [num_lanes*lane_w-1:0] dout_bits;

    assign adv_bits = adv;
    assign din_bits = data_in;
    assign data_out = dout_bits;

    // ==============================
    // Rate control
    // ==============================

    // Single control point for all lane rates
    rate_ctrl rate_ctrl_i (
        .gclk    (gclk),
        .rst_n   (rst_n),
        .enable  (enable),
        .lane_en (lane_en),
        .adv     (adv)
    );

    // ==============================
    // Lane pipelines
    // ==============================

    // Lane i reads its own strobe and byte, writes its own output byte
    for (genvar li = 0; li < num_lanes; li++) begin : g_lane
        lane_mix_pipe #(
            .lane_offset (lane_off[li])
        ) lane_mix_pipe_i (
            .gclk    (gclk),
            .rst_n   (rst_n),
            .advance (adv_bits[li]),
            .din     (din_bits[li*lane_w +: lane_w]),
            .dout    (dout_bits[li*lane_w +: lane_w])
        );
    end

endmodule

`default_nettype wire

/* design/lane_mix_pipe.sv */
// ==============================
// One lane's eight-stage byte mixing pipeline. All stages load together
// on the lane's advance strobe, dout is the last stage.
// ==============================

`default_nettype none

module lane_mix_pipe #(
    parameter clk_div_pkg::lane_byte_t lane_offset = 8'h00
) (
    input  logic                    gclk,
    input  logic                    rst_n,
    input  logic                    advance,
    input  clk_div_pkg::lane_byte_t din,
    output clk_div_pkg::lane_byte_t dout
);

    import clk_div_pkg::*;

    // ==============================
    // Stage storage
    // ==============================

    localparam int unsigned num_stages = 8;

    // Current stage contents, index 0 takes the input byte
    lane_byte_t stage [num_stages];

    // Values each stage loads on the next advance
    lane_byte_t stage_nxt [num_stages];

    // ==============================
    // Mixing chain
    // ==============================

    // Every stage reads only current stage values, so all stages shift
    // together and several bytes are in flight at once
    // Arithmetic wraps at 8 bits
    always_comb begin
        // Capture the lane byte
        stage_nxt[0] = din;

        // Add the lane's own offset
        stage_nxt[1] = stage[0] + lane_offset;

        // Mix with the raw captured byte
        stage_nxt[2] = stage[1] ^ stage[0];

        // Mask against the offset byte
        stage_nxt[3] = stage[2] & stage[1];

        // Merge bits back in
        stage_nxt[4] = stage[3] | stage[2];

        // Sum of the last two stages
        stage_nxt[5] = stage[4] + stage[3];

        // Difference, undoes part of the sum
        stage_nxt[6] = stage[5] - stage[4];

        // Final fold, becomes dout
        stage_nxt[7] = stage[6] ^ stage[5];
    end

    // ==============================
    // Stage registers
    // ==============================

    // Output only moves on an advance edge
    always_ff @(posedge gclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_stages; s++) begin
                stage[s] <= '0;
            end
        end else if (advance) begin
            for (int s = 0; s < num_stages; s++) begin
                stage[s] <= stage_nxt[s];
            end
        end
    end

    // A byte captured on one advance reaches dout after 7 more advances
    assign dout = stage[num_stages-1];

endmodule

`default_nettype wire

/* design/rate_ctrl.sv */
// ==============================
// Divide counter and per-lane advance strobes. Feeds every lane pipeline
// with one-cycle strobes, all in the gclk domain.
// ==============================

`default_nettype none

module rate_ctrl (
    input  logic                   gclk,
    input  logic                   rst_n,
    input  logic                   enable,
    input  clk_div_pkg::lane_en_t  lane_en,
    output clk_div_pkg::lane_adv_t adv
);

    import clk_div_pkg::*;

    // ==============================
    // Divide counter
    // ==============================

    // Free-running count, steps only while enable is high
    logic [div_cnt_w-1:0] div_cnt;

    // Raw rate ticks before lane gating
    logic tick_div2;
    logic tick_div4;
    logic tick_div8;

    // Wrap at 8 comes from the counter width
    // Holding on enable low keeps the phase, so rates resume in step
    always_ff @(posedge gclk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (enable) begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ==============================
    // Rate decode
    // ==============================

    // Each tick marks the edge where the old toggle divider would rise
    // Low bit set: every 2nd enabled edge
    assign tick_div2 = enable & div_cnt[0];

    // Low two bits set: every 4th enabled edge
    assign tick_div4 = enable & (&div_cnt[1:0]);

    // All bits set: every 8th enabled edge
    assign tick_div8 = enable & (&div_cnt);

    // Counter is 0 after reset, so the first div2 tick lands on edge 2,
    // div4 on edge 4 and div8 on edge 8

    // ==============================
    // Lane gating
    // ==============================

    // Lane enable takes the place of the old per-domain gate
    always_comb begin
        // Main lane runs at full gclk rate, only its enable applies
        adv.main = lane_en.main;

        // Divided lanes need both the rate tick and their own enable
        adv.div2 = tick_div2 & lane_en.div2;
        adv.div4 = tick_div4 & lane_en.div4;
        adv.div8 = tick_div8 & lane_en.div8;
    end

    // A disabled lane freezes while the counter keeps running,
    // so re-enabling it rejoins the common phase

endmodule

`default_nettype wire

/* design/clk_div_pkg.sv */
// ==============================
// Shared widths, lane offsets and lane-grouped types for the divided-rate
// byte mixer. Modules import it inside their body.
// ==============================

`default_nettype none

package clk_div_pkg;

    // ==============================
    // Widths and counts
    // ==============================

    // One lane carries one byte
    localparam int unsigned lane_w = 8;

    // Lane 0 main, lane 1 div2, lane 2 div4, lane 3 div8
    localparam int unsigned num_lanes = 4;

    // Divide counter wraps at 8, so div8 is the slowest rate
    localparam int unsigned div_cnt_w = 3;

    typedef logic [lane_w-1:0] lane_byte_t;

    // ==============================
    // Lane-grouped types
    // ==============================

    // Full data word, highest byte is the slowest lane
    typedef struct packed {
        lane_byte_t div8;
        lane_byte_t div4;
        lane_byte_t div2;
        lane_byte_t main;
    } lane_word_t;

    // Single-cycle advance strobes in the gclk domain
    typedef struct packed {
        logic div8;
        logic div4;
        logic div2;
        logic main;
    } lane_adv_t;

    // Per-lane enables, one per former gated domain
    typedef struct packed {
        logic div8;
        logic div4;
        logic div2;
        logic main;
    } lane_en_t;

    // Add offsets applied in stage 1 of each lane
    localparam lane_byte_t off_main = 8'hAA;
    localparam lane_byte_t off_div2 = 8'h01;
    localparam lane_byte_t off_div4 = 8'h02;
    localparam lane_byte_t off_div8 = 8'h04;

endpackage

`default_nettype wire
